//--- src/au_pkg.sv
// shared widths, constants and bundle types of the arithmetic unit.
// every file reaches these through scoped names.
package au_pkg;

   // data word width of the processor.
   localparam int unsigned au_dw = 32;

   // the restoring divider retires one quotient bit per step.
   localparam int unsigned au_div_steps = au_dw;

   // width of the divider step counter.
   localparam int unsigned au_div_cw = $clog2(au_div_steps);

   // counter value of the final divider step.
   localparam logic [au_div_cw-1:0] au_div_last = au_div_cw'(au_div_steps - 1);

   // one-hot opcode, so exactly one field is set in a valid request.
   typedef struct packed {
      logic add;
      logic sub;
      logic mul;
      logic div;
      logic divu;
      logic mod;
      logic modu;
   } au_opc_t;

   // input bundle handed over by the issue logic.
   typedef struct packed {
      au_opc_t           opc;
      logic [au_dw-1:0]  operand_1;
      logic [au_dw-1:0]  operand_2;
   } au_req_t;

   // result bundle of every engine and of the unit itself.
   // carry and overflow only mean something for add and sub.
   typedef struct packed {
      logic [au_dw-1:0]  result;
      logic              carry;
      logic              overflow;
   } au_rsp_t;

endpackage

//--- src/au_adder.sv
`timescale 1ns/1ps

// combinational adder shared by add and subtract.
module au_adder (
   input  au_pkg::au_opc_t          req_opc,
   input  logic [au_pkg::au_dw-1:0] operand_1,
   input  logic [au_pkg::au_dw-1:0] operand_2,
   output au_pkg::au_rsp_t          rsp
);

   logic                     is_sub;
   logic                     is_arith;
   logic [au_pkg::au_dw-1:0] operand_2_com;
   logic [au_pkg::au_dw:0]   sum;
   logic                     ovf;

   // subtraction is a + ~b + 1, so the carry-in equals the sub bit.
   assign is_sub        = req_opc.sub;
   assign is_arith      = req_opc.add | req_opc.sub;
   assign operand_2_com = is_sub ? ~operand_2 : operand_2;

   // one extra bit on top catches the carry-out.
   assign sum = {1'b0, operand_1} + {1'b0, operand_2_com} + {{au_pkg::au_dw{1'b0}}, is_sub};

   // overflow happens when both addends share a sign and the sum flips it.
   assign ovf = (operand_1[au_pkg::au_dw-1] == operand_2_com[au_pkg::au_dw-1]) &
                (operand_1[au_pkg::au_dw-1] ^ sum[au_pkg::au_dw-1]);

   // for subtract the raw carry-out reads as "no borrow".
   // the flags stay zero for any opcode outside add and sub.
   assign rsp.result   = sum[au_pkg::au_dw-1:0];
   assign rsp.carry    = is_arith & sum[au_pkg::au_dw];
   assign rsp.overflow = is_arith & ovf;

endmodule

//--- src/au_mul.sv
`timescale 1ns/1ps

// two-stage pipelined multiplier that keeps the low word of the product.
module au_mul (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     in_valid,
   input  logic [au_pkg::au_dw-1:0] operand_1,
   input  logic [au_pkg::au_dw-1:0] operand_2,
   output logic                     out_valid,
   output au_pkg::au_rsp_t          rsp
);

   logic        s1_valid;
   logic [31:0] pp_ll;
   logic [15:0] pp_lh;
   logic [15:0] pp_hl;
   logic [15:0] pp_cross;

   // stage one forms the partial products of the 16 bit halves.
   // the high by high product lies wholly above bit 31 and is never formed.
   // only the low half of each cross product reaches the low word.
   always_ff @(posedge clk) begin
      pp_ll <= {16'b0, operand_1[15:0]} * {16'b0, operand_2[15:0]};
      pp_lh <= operand_1[15:0] * operand_2[31:16];
      pp_hl <= operand_1[31:16] * operand_2[15:0];
   end

   // the cross terms are shifted up by 16, so their carry out is dropped.
   assign pp_cross = pp_lh + pp_hl;

   // stage two sums the low word terms and registers the response.
   always_ff @(posedge clk) begin
      rsp.result   <= pp_ll + {pp_cross, 16'b0};
      rsp.carry    <= 1'b0;
      rsp.overflow <= 1'b0;
   end

   // valid walks next to the data, so two products can be in flight.
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s1_valid  <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         s1_valid  <= in_valid;
         out_valid <= s1_valid;
      end
   end

endmodule

//--- src/au_div.sv
`timescale 1ns/1ps

// iterative restoring divider for signed and unsigned quotient and remainder.
module au_div (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     start,
   input  logic                     is_signed,
   input  logic                     want_rem,
   input  logic [au_pkg::au_dw-1:0] operand_1,
   input  logic [au_pkg::au_dw-1:0] operand_2,
   output logic                     done,
   output au_pkg::au_rsp_t          rsp
);

   logic                         neg_a;
   logic                         neg_b;
   logic [au_pkg::au_dw-1:0]     mag_a;
   logic [au_pkg::au_dw-1:0]     mag_b;
   logic                         running;
   logic                         fin;
   logic [au_pkg::au_div_cw-1:0] cnt;
   logic [au_pkg::au_dw-1:0]     quot;
   logic [au_pkg::au_dw-1:0]     rem;
   logic [au_pkg::au_dw-1:0]     dvsr;
   logic                         q_neg;
   logic                         r_neg;
   logic                         rem_sel;
   logic                         dz;
   logic [au_pkg::au_dw:0]       rem_sh;
   logic [au_pkg::au_dw:0]       diff;
   logic [au_pkg::au_dw-1:0]     q_fix;
   logic [au_pkg::au_dw-1:0]     r_fix;

   // the engine works on magnitudes and puts the signs back at the end.
   assign neg_a = is_signed & operand_1[au_pkg::au_dw-1];
   assign neg_b = is_signed & operand_2[au_pkg::au_dw-1];
   assign mag_a = neg_a ? -operand_1 : operand_1;
   assign mag_b = neg_b ? -operand_2 : operand_2;

   // one step shifts the next dividend bit into the partial remainder.
   // a clear sign bit on the difference means the divisor fits.
   assign rem_sh = {rem, quot[au_pkg::au_dw-1]};
   assign diff   = rem_sh - {1'b0, dvsr};

   // a zero divisor yields an all ones quotient.
   // min by -1 divides the magnitude by one with both signs set, so the
   // quotient already reads as the dividend and the remainder as zero.
   // the quotient truncates toward zero and the remainder follows the dividend.
   assign q_fix = dz ? '1 : q_neg ? -quot : quot;
   assign r_fix = r_neg ? -rem : rem;

   // the step control starts, runs au_div_steps iterations and then spends
   // one finishing cycle.
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         running <= 1'b0;
         fin     <= 1'b0;
         done    <= 1'b0;
         cnt     <= '0;
      end else begin
         done <= fin;
         fin  <= 1'b0;
         if (start) begin
            running <= 1'b1;
            cnt     <= '0;
         end else if (running) begin
            cnt <= cnt + 1'b1;
            if (cnt == au_pkg::au_div_last) begin
               running <= 1'b0;
               fin     <= 1'b1;
            end
         end
      end
   end

   // datapath registers load on start and shift while running.
   always_ff @(posedge clk) begin
      if (start) begin
         quot    <= mag_a;
         rem     <= '0;
         dvsr    <= mag_b;
         q_neg   <= neg_a ^ neg_b;
         r_neg   <= neg_a;
         rem_sel <= want_rem;
         dz      <= (operand_2 == '0);
      end else if (running) begin
         quot <= {quot[au_pkg::au_dw-2:0], ~diff[au_pkg::au_dw]};
         rem  <= diff[au_pkg::au_dw] ? rem_sh[au_pkg::au_dw-1:0] : diff[au_pkg::au_dw-1:0];
      end
      // the response is held in step with the done pulse.
      if (fin) begin
         rsp.result   <= rem_sel ? r_fix : q_fix;
         rsp.carry    <= 1'b0;
         rsp.overflow <= 1'b0;
      end
   end

endmodule

//--- src/au_ctrl.sv
`timescale 1ns/1ps

// accepts requests, steers them to the engines and registers the result.
module au_ctrl (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     in_valid,
   input  au_pkg::au_req_t          in_req,
   output logic                     in_ready,
   input  au_pkg::au_rsp_t          add_rsp,
   input  logic                     mul_out_valid,
   input  au_pkg::au_rsp_t          mul_rsp,
   input  logic                     div_done,
   input  au_pkg::au_rsp_t          div_rsp,
   output au_pkg::au_opc_t          add_opc,
   output logic [au_pkg::au_dw-1:0] oper_1,
   output logic [au_pkg::au_dw-1:0] oper_2,
   output logic                     mul_start,
   output logic                     div_start,
   output logic                     div_signed,
   output logic                     div_rem,
   output logic                     out_valid,
   output au_pkg::au_rsp_t          out_rsp
);

   logic            accept;
   logic            is_add;
   logic            is_mul;
   logic            is_div;
   logic            div_busy;
   logic            s1_valid;
   logic            s2_valid;
   au_pkg::au_rsp_t s1_rsp;
   au_pkg::au_rsp_t s2_rsp;

   // a request is taken when valid meets ready.
   assign accept = in_valid & in_ready;
   assign is_add = in_req.opc.add | in_req.opc.sub;
   assign is_mul = in_req.opc.mul;
   assign is_div = in_req.opc.div | in_req.opc.divu | in_req.opc.mod | in_req.opc.modu;

   // only a running divide holds off new requests.
   assign in_ready = ~div_busy;

   // the engines see the operands straight from the input.
   // each one acts only on its own start strobe.
   assign add_opc    = in_req.opc;
   assign oper_1     = in_req.operand_1;
   assign oper_2     = in_req.operand_2;
   assign mul_start  = accept & is_mul;
   assign div_start  = accept & is_div;
   assign div_signed = in_req.opc.div | in_req.opc.mod;
   assign div_rem    = in_req.opc.mod | in_req.opc.modu;

   // adder results pass two stages here to line up with the multiplier.
   always_ff @(posedge clk) begin
      s1_rsp <= add_rsp;
      s2_rsp <= s1_rsp;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s1_valid  <= 1'b0;
         s2_valid  <= 1'b0;
         div_busy  <= 1'b0;
         out_valid <= 1'b0;
      end else begin
         s1_valid <= accept & is_add;
         s2_valid <= s1_valid;
         // busy falls on the same edge that presents the divide result.
         if (div_start) begin
            div_busy <= 1'b1;
         end else if (div_done) begin
            div_busy <= 1'b0;
         end
         out_valid <= s2_valid | mul_out_valid | div_done;
      end
   end

   // at most one source is valid in a cycle, so the order here is arbitrary.
   always_ff @(posedge clk) begin
      if (div_done) begin
         out_rsp <= div_rsp;
      end else if (mul_out_valid) begin
         out_rsp <= mul_rsp;
      end else if (s2_valid) begin
         out_rsp <= s2_rsp;
      end
   end

endmodule

//--- src/au_top.sv
`timescale 1ns/1ps

// arithmetic unit of the execute stage.
// the control block feeds the three engines and merges their results.
module au_top (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            in_valid,
   input  au_pkg::au_req_t in_req,
   output logic            in_ready,
   output logic            out_valid,
   output au_pkg::au_rsp_t out_rsp
);

   au_pkg::au_rsp_t          add_rsp;
   au_pkg::au_rsp_t          mul_rsp;
   au_pkg::au_rsp_t          div_rsp;
   au_pkg::au_opc_t          add_opc;
   logic [au_pkg::au_dw-1:0] oper_1;
   logic [au_pkg::au_dw-1:0] oper_2;
   logic                     mul_start;
   logic                     mul_out_valid;
   logic                     div_start;
   logic                     div_signed;
   logic                     div_rem;
   logic                     div_done;

   au_ctrl u_ctrl (
      .clk           (clk),
      .rst_n         (rst_n),
      .in_valid      (in_valid),
      .in_req        (in_req),
      .in_ready      (in_ready),
      .add_rsp       (add_rsp),
      .mul_out_valid (mul_out_valid),
      .mul_rsp       (mul_rsp),
      .div_done      (div_done),
      .div_rsp       (div_rsp),
      .add_opc       (add_opc),
      .oper_1        (oper_1),
      .oper_2        (oper_2),
      .mul_start     (mul_start),
      .div_start     (div_start),
      .div_signed    (div_signed),
      .div_rem       (div_rem),
      .out_valid     (out_valid),
      .out_rsp       (out_rsp)
   );

   // the adder is purely combinational.
   au_adder u_adder (
      .req_opc   (add_opc),
      .operand_1 (oper_1),
      .operand_2 (oper_2),
      .rsp       (add_rsp)
   );

   au_mul u_mul (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (mul_start),
      .operand_1 (oper_1),
      .operand_2 (oper_2),
      .out_valid (mul_out_valid),
      .rsp       (mul_rsp)
   );

   au_div u_div (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (div_start),
      .is_signed (div_signed),
      .want_rem  (div_rem),
      .operand_1 (oper_1),
      .operand_2 (oper_2),
      .done      (div_done),
      .rsp       (div_rsp)
   );

endmodule

//--- tests/au_asserts.sv
`timescale 1ns/1ps

// protocol properties of the control block, attached with bind.
module au_asserts (
   input logic clk,
   input logic rst_n,
   input logic div_start,
   input logic div_done,
   input logic in_ready,
   input logic out_valid
);

   // a divide that starts must close the input from the next cycle on.
   a_ready_drops: assert property (@(posedge clk) disable iff (!rst_n)
      div_start |=> !in_ready)
      else $error("in_ready stayed high after a divide was accepted");

   // the divide result is a single strobe, the cycle after it stays quiet.
   a_div_strobe: assert property (@(posedge clk) disable iff (!rst_n)
      (out_valid && $past(div_done)) |=> !out_valid)
      else $error("out_valid held for two cycles at the end of a divide");

   // reset clears the output strobe and opens the input.
   a_reset_state: assert property (@(posedge clk)
      !rst_n |=> (!out_valid && in_ready))
      else $error("out_valid or in_ready wrong after reset");

endmodule

bind au_ctrl au_asserts u_asserts (
   .clk       (clk),
   .rst_n     (rst_n),
   .div_start (div_start),
   .div_done  (div_done),
   .in_ready  (in_ready),
   .out_valid (out_valid)
);

//--- tests/au_tb.sv
`timescale 1ns/1ps

// self-checking testbench for the arithmetic unit with a reference model.
module au_tb;

   localparam int unsigned n_req    = 600;
   localparam int unsigned n_corner = 4;
   localparam int unsigned clk_ns   = 40;
   localparam int unsigned div_lat  = au_pkg::au_div_steps + 2;
   // every request may take the full divide latency plus some slack.
   localparam int unsigned limit_ns = (n_req * (au_pkg::au_div_steps + 4) + 20) * clk_ns;

   // one expected result together with the cycle it is due in.
   typedef struct packed {
      logic [31:0]     due;
      au_pkg::au_rsp_t rsp;
   } expect_t;

   logic            clk;
   logic            rst_n;
   logic            in_valid;
   au_pkg::au_req_t in_req;
   logic            in_ready;
   logic            out_valid;
   au_pkg::au_rsp_t out_rsp;
   integer          seed;
   int unsigned     cyc = 0;
   int unsigned     ready_cyc;
   int unsigned     sent;
   logic            taken;
   expect_t         exp_q[$];

   au_top uut (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_req    (in_req),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_rsp   (out_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_ns / 2) clk = ~clk;
   end

   // cyc counts rising edges and reads N between edge N and edge N+1.
   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   // reference model built from the arithmetic rules of the unit.
   function automatic au_pkg::au_rsp_t model_rsp(au_pkg::au_req_t req);
      au_pkg::au_rsp_t r;
      logic [31:0]     a;
      logic [31:0]     b;
      logic [32:0]     wide;
      a = req.operand_1;
      b = req.operand_2;
      r = '0;
      if (req.opc.add) begin
         wide = {1'b0, a} + {1'b0, b};
         r.result = wide[31:0];
         r.carry = wide[32];
         r.overflow = (a[31] == b[31]) && (wide[31] != a[31]);
      end else if (req.opc.sub) begin
         // carry is set when no borrow is needed.
         r.result = a - b;
         r.carry = (a >= b);
         r.overflow = (a[31] != b[31]) && (r.result[31] != a[31]);
      end else if (req.opc.mul) begin
         r.result = a * b;
      end else if (b == 32'd0) begin
         r.result = (req.opc.mod || req.opc.modu) ? a : 32'hffff_ffff;
      end else if ((req.opc.div || req.opc.mod) && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
         r.result = req.opc.div ? a : 32'd0;
      end else if (req.opc.div) begin
         r.result = $signed(a) / $signed(b);
      end else if (req.opc.mod) begin
         r.result = $signed(a) % $signed(b);
      end else if (req.opc.divu) begin
         r.result = a / b;
      end else begin
         r.result = a % b;
      end
      return r;
   endfunction

   // the first requests pin min by -1 and a zero divisor for div and mod.
   function automatic au_pkg::au_req_t corner_req(int unsigned idx);
      au_pkg::au_req_t r;
      r = '0;
      r.operand_1 = 32'h8000_0000;
      r.operand_2 = (idx < 2) ? 32'hffff_ffff : 32'd0;
      if ((idx % 2) == 0) begin
         r.opc.div = 1'b1;
      end else begin
         r.opc.mod = 1'b1;
      end
      return r;
   endfunction

   // add, sub and mul are drawn more often so they run back to back.
   function automatic au_pkg::au_opc_t pick_opc();
      au_pkg::au_opc_t o;
      int unsigned     k;
      o = '0;
      k = $unsigned($random(seed)) % 10;
      case (k)
         0, 1: o.add = 1'b1;
         2, 3: o.sub = 1'b1;
         4, 5: o.mul = 1'b1;
         6: o.div = 1'b1;
         7: o.divu = 1'b1;
         8: o.mod = 1'b1;
         default: o.modu = 1'b1;
      endcase
      return o;
   endfunction

   // corner values show up in more than half of all operands.
   function automatic logic [31:0] pick_operand();
      int unsigned k;
      k = $unsigned($random(seed)) % 8;
      case (k)
         0: return 32'd0;
         1: return 32'hffff_ffff;
         2: return 32'h8000_0000;
         3: return 32'h7fff_ffff;
         4: return 32'd1;
         default: return $random(seed);
      endcase
   endfunction

   // records an accepted request whose result is due two or div_lat edges later.
   task automatic push_expect();
      expect_t e;
      e.rsp = model_rsp(in_req);
      if (in_req.opc.add || in_req.opc.sub || in_req.opc.mul) begin
         e.due = cyc + 1 + 2;
      end else begin
         e.due = cyc + 1 + div_lat;
         ready_cyc = cyc + 1 + div_lat;
      end
      exp_q.push_back(e);
      sent = sent + 1;
   endtask

   // a request that was not taken stays on the bus unchanged.
   task automatic drive_next();
      if (!in_valid || taken) begin
         if (sent < n_corner) begin
            in_valid = 1'b1;
            in_req = corner_req(sent);
         end else if (sent < n_req && ($unsigned($random(seed)) % 4) != 0) begin
            in_valid = 1'b1;
            in_req.opc = pick_opc();
            in_req.operand_1 = pick_operand();
            in_req.operand_2 = pick_operand();
         end else begin
            in_valid = 1'b0;
         end
      end
      // in_ready is stable until the next rising edge, so acceptance is known now.
      taken = in_valid && in_ready;
      if (taken) begin
         push_expect();
      end
   endtask

   task automatic check_outputs();
      logic    exp_valid;
      logic    exp_ready;
      expect_t head;
      exp_valid = 1'b0;
      if (exp_q.size() > 0) begin
         exp_valid = (exp_q[0].due == cyc);
      end
      exp_ready = (cyc >= ready_cyc);
      assert (in_ready === exp_ready) else begin
         $display("FAIL %0t in_ready expected %0b actual %0b", $time, exp_ready, in_ready);
         $display("*** FAILED ***");
         $fatal(1, "in_ready mismatch");
      end
      assert (out_valid === exp_valid) else begin
         $display("FAIL %0t out_valid expected %0b actual %0b", $time, exp_valid, out_valid);
         $display("*** FAILED ***");
         $fatal(1, "out_valid mismatch");
      end
      if (exp_valid) begin
         head = exp_q.pop_front();
         assert (out_rsp === head.rsp) else begin
            $display("FAIL %0t out_rsp expected %h actual %h", $time, head.rsp, out_rsp);
            $display("*** FAILED ***");
            $fatal(1, "out_rsp mismatch");
         end
      end
   endtask

   initial begin
      seed = 32'h182fee1a;
      rst_n = 1'b0;
      in_valid = 1'b0;
      in_req = '0;
      taken = 1'b0;
      sent = 0;
      ready_cyc = 0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      // right after reset the output is quiet and the input is open.
      check_outputs();
      while (sent < n_req || exp_q.size() != 0) begin
         drive_next();
         @(negedge clk);
         check_outputs();
      end
      // no result may appear once every request has been answered.
      in_valid = 1'b0;
      repeat (4) begin
         @(negedge clk);
         check_outputs();
      end
      $display("*** PASSED ***");
      $finish;
   end

   initial begin
      #(limit_ns);
      $display("watchdog expired after %0d ns with results still outstanding", limit_ns);
      $display("*** FAILED ***");
      $fatal(1, "timeout");
   end

endmodule

//--- filelist.f
src/au_pkg.sv
src/au_adder.sv
src/au_mul.sv
src/au_div.sv
src/au_ctrl.sv
src/au_top.sv
tests/au_asserts.sv
tests/au_tb.sv

//--- Makefile
# Verilator flow for the arithmetic unit testbench.
TOP = au_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/1ps \
		-f filelist.f --top-module $(TOP)

# the run exits with a non-zero status when the testbench stops on $fatal.
sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		-f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
